//--- rtl/fp_cmp_cfg.svh
// Configuration of the single-precision compare unit.
// Field widths of an operand, the integer result width and the
// canonical quiet NaN returned by min and max when both inputs are NaN.

`ifndef FP_CMP_CFG_SVH
`define FP_CMP_CFG_SVH

`define FP_EXP_WIDTH 8   // biased exponent field.
`define FP_FRAC_WIDTH 23 // fraction field without the hidden bit.

// sign, exponent and fraction together.
`define FP_WIDTH (1 + `FP_EXP_WIDTH + `FP_FRAC_WIDTH)

`define XLEN 32 // width of the integer result of eq, lt and le.

// positive, exponent all ones, only the quiet bit set in the fraction.
`define FP_CANON_QNAN 32'h7fc0_0000

`endif

//--- rtl/fp_cmp_pkg.sv
// Types shared by the floating-point compare unit.
// Operand and result words, the command encoding, and the structs
// that carry operand classification and ordering to the result selector.

`default_nettype none

`include "fp_cmp_cfg.svh"

package fp_cmp_pkg;

    typedef logic [`FP_WIDTH-1:0]      fp_word_t;  // operand or fp result.
    typedef logic [`FP_EXP_WIDTH-1:0]  fp_exp_t;
    typedef logic [`FP_FRAC_WIDTH-1:0] fp_frac_t;
    typedef logic [`XLEN-1:0]          int_word_t; // integer result.

    typedef enum logic [2:0] {
        cmd_eq  = 3'd0,
        cmd_lt  = 3'd1,
        cmd_le  = 3'd2,
        cmd_min = 3'd3,
        cmd_max = 3'd4
    } fp_cmp_cmd_e;

    // properties of both operands, decoded once in the classifier.
    typedef struct packed {
        logic sign1;
        logic sign2;
        logic is_zero1;
        logic is_zero2;
        logic is_nan1;
        logic is_nan2;
        logic is_snan1;
        logic is_snan2;
        logic both_zero;
        logic any_nan;
        logic any_snan;
        logic both_nan;
    } fp_pair_class_t;

    // ordering of src1 against src2, only valid when neither is NaN.
    typedef struct packed {
        logic eq_bits;  // identical bit patterns.
        logic lt_value; // src1 numerically below src2.
        logic eq_value; // numerically equal, +0 equals -0.
    } fp_order_t;

endpackage

`default_nettype wire

//--- rtl/fp_pair_classifier.sv
// Operand classifier of the compare unit.
// Decodes zero, NaN and signaling NaN for both operands and forms the
// joint conditions used by the result selector. Purely combinational.

`default_nettype none

`include "fp_cmp_cfg.svh"

module fp_pair_classifier (
    input  fp_cmp_pkg::fp_word_t       src1,
    input  fp_cmp_pkg::fp_word_t       src2,
    output fp_cmp_pkg::fp_pair_class_t pair_class
);

    // returns {is_zero, is_nan, is_snan} for one operand.
    function automatic logic [2:0] decode_operand(input fp_cmp_pkg::fp_word_t word);
        fp_cmp_pkg::fp_exp_t  exp_field;
        fp_cmp_pkg::fp_frac_t frac_field;
        logic                 zero;
        logic                 nan;
        logic                 snan;
        exp_field  = word[`FP_WIDTH-2 -: `FP_EXP_WIDTH];
        frac_field = word[`FP_FRAC_WIDTH-1:0];
        zero = (exp_field == '0) && (frac_field == '0);
        nan  = (exp_field == '1) && (frac_field != '0);
        snan = nan && !frac_field[`FP_FRAC_WIDTH-1]; // quiet bit clear.
        return {zero, nan, snan};
    endfunction

    logic [2:0] props1;
    logic [2:0] props2;

    assign props1 = decode_operand(src1);
    assign props2 = decode_operand(src2);

    always_comb begin
        pair_class.sign1    = src1[`FP_WIDTH-1];
        pair_class.sign2    = src2[`FP_WIDTH-1];
        pair_class.is_zero1 = props1[2];
        pair_class.is_zero2 = props2[2];
        pair_class.is_nan1  = props1[1];
        pair_class.is_nan2  = props2[1];
        pair_class.is_snan1 = props1[0];
        pair_class.is_snan2 = props2[0];

        // joint conditions, so the selector never decodes them again.
        pair_class.both_zero = pair_class.is_zero1 & pair_class.is_zero2;
        pair_class.any_nan   = pair_class.is_nan1 | pair_class.is_nan2;
        pair_class.any_snan  = pair_class.is_snan1 | pair_class.is_snan2;
        pair_class.both_nan  = pair_class.is_nan1 & pair_class.is_nan2;
    end

endmodule

`default_nettype wire

//--- rtl/fp_order_compare.sv
// Order comparator of the compare unit.
// Treats both operands as sign-magnitude numbers and tells whether
// src1 is below or equal to src2. NaN inputs are not considered here.

`default_nettype none

`include "fp_cmp_cfg.svh"

module fp_order_compare (
    input  fp_cmp_pkg::fp_word_t  src1,
    input  fp_cmp_pkg::fp_word_t  src2,
    output fp_cmp_pkg::fp_order_t order
);

    logic                 sign1;
    logic                 sign2;
    fp_cmp_pkg::fp_exp_t  exp1;
    fp_cmp_pkg::fp_exp_t  exp2;
    fp_cmp_pkg::fp_frac_t frac1;
    fp_cmp_pkg::fp_frac_t frac2;

    assign sign1 = src1[`FP_WIDTH-1];
    assign sign2 = src2[`FP_WIDTH-1];
    assign exp1  = src1[`FP_WIDTH-2 -: `FP_EXP_WIDTH];
    assign exp2  = src2[`FP_WIDTH-2 -: `FP_EXP_WIDTH];
    assign frac1 = src1[`FP_FRAC_WIDTH-1:0];
    assign frac2 = src2[`FP_FRAC_WIDTH-1:0];

    logic both_zero; // +0 and -0 are the same value.
    logic mag_lt;    // magnitude of src1 below that of src2.
    logic mag_eq;

    always_comb begin
        both_zero = (src1[`FP_WIDTH-2:0] == '0) && (src2[`FP_WIDTH-2:0] == '0);
        mag_eq    = (exp1 == exp2) && (frac1 == frac2);
        mag_lt    = (exp1 < exp2) || ((exp1 == exp2) && (frac1 < frac2));
    end

    always_comb begin
        order.eq_bits  = (src1 == src2);
        order.eq_value = order.eq_bits | both_zero;

        if (sign1 != sign2) begin
            // the negative one is lower unless both are zero.
            order.lt_value = sign1 & !both_zero;
        end else if (sign1) begin
            // both negative, a larger magnitude is the lower value.
            order.lt_value = !mag_lt & !mag_eq;
        end else begin
            order.lt_value = mag_lt;
        end
    end

endmodule

`default_nettype wire

//--- rtl/fp_compare_select.sv
// Result selector of the compare unit.
// Combines the operand classification and the ordering with the command
// to form the integer result, the fp result of min and max and the
// invalid-operation flag, and registers them for one cycle of latency.

`default_nettype none

`include "fp_cmp_cfg.svh"

module fp_compare_select (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       in_valid,
    input  fp_cmp_pkg::fp_cmp_cmd_e    command,
    input  fp_cmp_pkg::fp_word_t       src1,
    input  fp_cmp_pkg::fp_word_t       src2,
    input  fp_cmp_pkg::fp_pair_class_t pair_class,
    input  fp_cmp_pkg::fp_order_t      order,
    output logic                       out_valid,
    output fp_cmp_pkg::int_word_t      int_result,
    output fp_cmp_pkg::fp_word_t       fp_result,
    output logic                       invalid_flag
);

    logic                  relation_holds;
    logic                  invalid_next;
    fp_cmp_pkg::int_word_t int_next;
    fp_cmp_pkg::fp_word_t  fp_next;

    // integer result of eq, lt and le.
    always_comb begin
        case (command)
            fp_cmp_pkg::cmd_eq: relation_holds = order.eq_value;
            fp_cmp_pkg::cmd_lt: relation_holds = order.lt_value;
            fp_cmp_pkg::cmd_le: relation_holds = order.lt_value | order.eq_value;
            default:            relation_holds = 1'b0; // min and max give 0.
        endcase

        int_next    = '0;
        int_next[0] = relation_holds & !pair_class.any_nan; // NaN never compares true.
    end

    // min and max pick an fp result, and the compare commands give zero.
    always_comb begin
        if (command != fp_cmp_pkg::cmd_min && command != fp_cmp_pkg::cmd_max) begin
            fp_next = '0;
        end else if (pair_class.both_nan) begin
            fp_next = `FP_CANON_QNAN;
        end else if (pair_class.is_nan1) begin
            fp_next = src2; // a single NaN yields the other operand.
        end else if (pair_class.is_nan2) begin
            fp_next = src1;
        end else if (pair_class.both_zero) begin
            // -0 is taken as the smaller of the two zeros.
            if (command == fp_cmp_pkg::cmd_max) begin
                fp_next = pair_class.sign1 ? src2 : src1;
            end else begin
                fp_next = pair_class.sign1 ? src1 : src2;
            end
        end else if (command == fp_cmp_pkg::cmd_max) begin
            fp_next = order.lt_value ? src2 : src1;
        end else begin
            fp_next = order.lt_value ? src1 : src2;
        end
    end

    // lt and le signal on any NaN and the others only on a signaling NaN.
    always_comb begin
        case (command)
            fp_cmp_pkg::cmd_lt,
            fp_cmp_pkg::cmd_le:  invalid_next = pair_class.any_nan;
            fp_cmp_pkg::cmd_eq,
            fp_cmp_pkg::cmd_min,
            fp_cmp_pkg::cmd_max: invalid_next = pair_class.any_snan;
            default:             invalid_next = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid    <= 1'b0;
            int_result   <= '0;
            fp_result    <= '0;
            invalid_flag <= 1'b0;
        end else begin
            out_valid <= in_valid; // one pulse per accepted operation.
            if (in_valid) begin
                int_result   <= int_next;
                fp_result    <= fp_next;
                invalid_flag <= invalid_next;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/fp_compare_unit.sv
// Single-precision floating-point compare unit.
// Produces the results of FEQ.S, FLT.S, FLE.S, FMIN.S and FMAX.S with the
// invalid-operation flag, one cycle after each operation is accepted.
// Classifier and order comparator run side by side and feed the selector.

`default_nettype none

module fp_compare_unit (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    in_valid,
    input  fp_cmp_pkg::fp_cmp_cmd_e command,
    input  fp_cmp_pkg::fp_word_t    src1,
    input  fp_cmp_pkg::fp_word_t    src2,
    output logic                    out_valid,
    output fp_cmp_pkg::int_word_t   int_result,
    output fp_cmp_pkg::fp_word_t    fp_result,
    output logic                    invalid_flag
);

    fp_cmp_pkg::fp_pair_class_t pair_class;
    fp_cmp_pkg::fp_order_t      order;

    fp_pair_classifier fp_pair_classifier_inst (
        .src1       (src1),
        .src2       (src2),
        .pair_class (pair_class)
    );

    fp_order_compare fp_order_compare_inst (
        .src1  (src1),
        .src2  (src2),
        .order (order)
    );

    fp_compare_select fp_compare_select_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .command      (command),
        .src1         (src1),
        .src2         (src2),
        .pair_class   (pair_class),
        .order        (order),
        .out_valid    (out_valid),
        .int_result   (int_result),
        .fp_result    (fp_result),
        .invalid_flag (invalid_flag)
    );

endmodule

`default_nettype wire

//--- verification/fp_compare_checker.sv
// Bound checker of the floating-point compare unit.
// Recomputes every result from the accepted operands with its own
// reference model, and checks out_valid and the held outputs each cycle.

`default_nettype none

`include "fp_cmp_cfg.svh"

module fp_compare_checker (
    input logic                    clk,
    input logic                    rst_n,
    input logic                    in_valid,
    input fp_cmp_pkg::fp_cmp_cmd_e command,
    input fp_cmp_pkg::fp_word_t    src1,
    input fp_cmp_pkg::fp_word_t    src2,
    input logic                    out_valid,
    input fp_cmp_pkg::int_word_t   int_result,
    input fp_cmp_pkg::fp_word_t    fp_result,
    input logic                    invalid_flag
);
    timeunit 1ns;
    timeprecision 100ps;

    typedef struct packed {
        fp_cmp_pkg::int_word_t int_val;
        fp_cmp_pkg::fp_word_t  fp_val;
        logic                  invalid;
    } expect_t;

    int unsigned valid_errors   = 0;
    int unsigned int_errors     = 0;
    int unsigned fp_errors      = 0;
    int unsigned invalid_errors = 0;

    logic    check_due; // an operation was accepted on the previous edge.
    expect_t expected;

    function automatic logic is_nan(input fp_cmp_pkg::fp_word_t w);
        return (&w[`FP_WIDTH-2:`FP_FRAC_WIDTH]) && (|w[`FP_FRAC_WIDTH-1:0]);
    endfunction

    function automatic logic is_snan(input fp_cmp_pkg::fp_word_t w);
        return is_nan(w) && !w[`FP_FRAC_WIDTH-1];
    endfunction

    // Unsigned key that grows with the value, -0 lies just below +0.
    function automatic fp_cmp_pkg::fp_word_t order_key(input fp_cmp_pkg::fp_word_t w);
        fp_cmp_pkg::fp_word_t key;
        key = w;
        if (w[`FP_WIDTH-1]) begin
            key = ~w;
        end else begin
            key[`FP_WIDTH-1] = 1'b1;
        end
        return key;
    endfunction

    function automatic fp_cmp_pkg::fp_word_t value_key(input fp_cmp_pkg::fp_word_t w);
        fp_cmp_pkg::fp_word_t key;
        key = order_key(w);
        if (w[`FP_WIDTH-2:0] == '0) begin
            key = order_key('0); // both zeros are one value when comparing.
        end
        return key;
    endfunction

    function automatic expect_t reference_result(input fp_cmp_pkg::fp_cmp_cmd_e cmd,
                                                 input fp_cmp_pkg::fp_word_t    a,
                                                 input fp_cmp_pkg::fp_word_t    b);
        expect_t res;
        logic    unordered;
        logic    signaling;
        logic    a_first;
        res       = '0;
        unordered = is_nan(a) || is_nan(b);
        signaling = is_snan(a) || is_snan(b);
        a_first   = order_key(a) <= order_key(b);
        case (cmd)
            fp_cmp_pkg::cmd_eq: begin
                res.int_val[0] = !unordered && (value_key(a) == value_key(b));
                res.invalid    = signaling;
            end
            fp_cmp_pkg::cmd_lt: begin
                res.int_val[0] = !unordered && (value_key(a) < value_key(b));
                res.invalid    = unordered;
            end
            fp_cmp_pkg::cmd_le: begin
                res.int_val[0] = !unordered && (value_key(a) <= value_key(b));
                res.invalid    = unordered;
            end
            fp_cmp_pkg::cmd_min,
            fp_cmp_pkg::cmd_max: begin
                res.invalid = signaling;
                if (is_nan(a) && is_nan(b)) begin
                    res.fp_val = `FP_CANON_QNAN;
                end else if (is_nan(a)) begin
                    res.fp_val = b;
                end else if (is_nan(b)) begin
                    res.fp_val = a;
                end else if (cmd == fp_cmp_pkg::cmd_min) begin
                    res.fp_val = a_first ? a : b;
                end else begin
                    res.fp_val = a_first ? b : a;
                end
            end
            default: begin
                res = '0;
            end
        endcase
        return res;
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            check_due <= 1'b0;
            expected  <= '0;
        end else begin
            check_due <= in_valid;
            if (in_valid) begin
                expected <= reference_result(command, src1, src2);
            end
        end
    end

    // Results are compared every cycle, so a held value is checked as well.
    assert property (@(posedge clk) disable iff (!rst_n) out_valid == check_due)
        else begin
            $error("ERROR t=%0t out_valid expected %b got %b",
                   $time, $sampled(check_due), $sampled(out_valid));
            valid_errors++;
        end

    assert property (@(posedge clk) disable iff (!rst_n) int_result == expected.int_val)
        else begin
            $error("ERROR t=%0t int_result expected %h got %h",
                   $time, $sampled(expected.int_val), $sampled(int_result));
            int_errors++;
        end

    assert property (@(posedge clk) disable iff (!rst_n) fp_result == expected.fp_val)
        else begin
            $error("ERROR t=%0t fp_result expected %h got %h",
                   $time, $sampled(expected.fp_val), $sampled(fp_result));
            fp_errors++;
        end

    assert property (@(posedge clk) disable iff (!rst_n) invalid_flag == expected.invalid)
        else begin
            $error("ERROR t=%0t invalid_flag expected %b got %b",
                   $time, $sampled(expected.invalid), $sampled(invalid_flag));
            invalid_errors++;
        end

endmodule

bind fp_compare_unit fp_compare_checker fp_compare_checker_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .in_valid     (in_valid),
    .command      (command),
    .src1         (src1),
    .src2         (src2),
    .out_valid    (out_valid),
    .int_result   (int_result),
    .fp_result    (fp_result),
    .invalid_flag (invalid_flag)
);

`default_nettype wire

//--- verification/fp_compare_tb.sv
// Testbench of the floating-point compare unit.
// Runs every command over all pairs of a table of special operands, then
// random operations with idle gaps. The bound checker does the checking.

`default_nettype none

`include "fp_cmp_cfg.svh"

module fp_compare_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int RESET_CYCLES = 16;
    localparam int NUM_SPECIALS = 16;
    localparam int NUM_COMMANDS = 5;
    localparam int DIRECTED_OPS = NUM_SPECIALS * NUM_SPECIALS * NUM_COMMANDS;
    localparam int RANDOM_OPS   = 2000;
    localparam int MAX_IDLE     = RANDOM_OPS / 8; // cap on idle gaps in the random phase.
    localparam int DRAIN_CYCLES = 3;
    localparam int CYCLE_LIMIT  = RESET_CYCLES + DIRECTED_OPS + RANDOM_OPS + MAX_IDLE
                                  + DRAIN_CYCLES + 200;

    logic                    clk;
    logic                    rst_n;
    logic                    in_valid;
    fp_cmp_pkg::fp_cmp_cmd_e command;
    fp_cmp_pkg::fp_word_t    src1;
    fp_cmp_pkg::fp_word_t    src2;
    logic                    out_valid;
    fp_cmp_pkg::int_word_t   int_result;
    fp_cmp_pkg::fp_word_t    fp_result;
    logic                    invalid_flag;

    integer      seed;
    int unsigned cycle_count;
    int unsigned idle_count;

    fp_cmp_pkg::fp_word_t specials [NUM_SPECIALS] = '{
        32'h0000_0000, 32'h8000_0000,  // +0 and -0.
        32'h3f80_0000, 32'hbf80_0000,  // +1.0 and -1.0.
        32'h3f80_0001, 32'h4000_0000,  // one ulp above 1.0, and 2.0.
        32'h7f80_0000, 32'hff80_0000,  // infinities.
        32'h7fc0_0000, 32'hffc0_0001,  // quiet NaNs.
        32'h7f80_0001, 32'hff80_0010,  // signaling NaNs.
        32'h0000_0001, 32'h807f_ffff,  // denormals.
        32'h7f7f_ffff, 32'hff7f_ffff   // largest finite values.
    };

    fp_compare_unit fp_compare_unit_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .command      (command),
        .src1         (src1),
        .src2         (src2),
        .out_valid    (out_valid),
        .int_result   (int_result),
        .fp_result    (fp_result),
        .invalid_flag (invalid_flag)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic fp_cmp_pkg::fp_word_t random_operand();
        logic [31:0] r;
        r = $random(seed);
        if (r[2:0] == 3'd0) begin
            return specials[r[7:4]]; // a special value one time in eight.
        end
        return $random(seed);
    endfunction

    task automatic apply_operation(input fp_cmp_pkg::fp_cmp_cmd_e cmd,
                                   input fp_cmp_pkg::fp_word_t    a,
                                   input fp_cmp_pkg::fp_word_t    b);
        @(negedge clk);
        in_valid = 1'b1;
        command  = cmd;
        src1     = a;
        src2     = b;
    endtask

    // Operands keep changing while idle, the outputs must not follow them.
    task automatic idle_cycle();
        @(negedge clk);
        in_valid = 1'b0;
        src1     = $random(seed);
        src2     = $random(seed);
    endtask

    task automatic run_directed();
        for (int c = 0; c < NUM_COMMANDS; c++) begin
            for (int i = 0; i < NUM_SPECIALS; i++) begin
                for (int j = 0; j < NUM_SPECIALS; j++) begin
                    apply_operation(fp_cmp_pkg::fp_cmp_cmd_e'(3'(c)), specials[i], specials[j]);
                end
            end
        end
    endtask

    task automatic run_random();
        fp_cmp_pkg::fp_word_t    a;
        fp_cmp_pkg::fp_word_t    b;
        fp_cmp_pkg::fp_cmp_cmd_e cmd;
        logic [31:0]             pick;
        for (int n = 0; n < RANDOM_OPS; n++) begin
            a    = random_operand();
            pick = $random(seed);
            b    = random_operand();
            if (pick[2:0] == 3'd0) begin
                b = a; // identical operands.
            end else if (pick[2:0] == 3'd1) begin
                b = a;
                b[`FP_WIDTH-1] = ~a[`FP_WIDTH-1]; // same magnitude, other sign.
            end
            cmd = fp_cmp_pkg::fp_cmp_cmd_e'(3'(pick[31:8] % NUM_COMMANDS));
            apply_operation(cmd, a, b);
            if (pick[6:4] == 3'd0 && idle_count < MAX_IDLE) begin
                idle_cycle();
                idle_count++;
            end
        end
    endtask

    task automatic finish_run(input bit timed_out);
        int unsigned total;
        total = fp_compare_unit_inst.fp_compare_checker_inst.valid_errors
              + fp_compare_unit_inst.fp_compare_checker_inst.int_errors
              + fp_compare_unit_inst.fp_compare_checker_inst.fp_errors
              + fp_compare_unit_inst.fp_compare_checker_inst.invalid_errors
              + (timed_out ? 1 : 0);
        $display("errors: out_valid %0d, int_result %0d, fp_result %0d, invalid_flag %0d, timeout %0d",
                 fp_compare_unit_inst.fp_compare_checker_inst.valid_errors,
                 fp_compare_unit_inst.fp_compare_checker_inst.int_errors,
                 fp_compare_unit_inst.fp_compare_checker_inst.fp_errors,
                 fp_compare_unit_inst.fp_compare_checker_inst.invalid_errors,
                 timed_out);
        if (total == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout reached: the run did not end within %0d cycles", CYCLE_LIMIT);
        finish_run(1'b1);
    end

    initial begin
        seed       = 32'h7e19;
        idle_count = 0;
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        command    = fp_cmp_pkg::cmd_eq;
        src1       = '0;
        src2       = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;

        run_directed();
        run_random();

        // The last result and the following idle cycle still get checked.
        repeat (DRAIN_CYCLES) idle_cycle();
        finish_run(1'b0);
    end

endmodule

`default_nettype wire

//--- files.f
+incdir+rtl
rtl/fp_cmp_pkg.sv
rtl/fp_pair_classifier.sv
rtl/fp_order_compare.sv
rtl/fp_compare_select.sv
rtl/fp_compare_unit.sv
verification/fp_compare_checker.sv
verification/fp_compare_tb.sv

//--- Bender.yml
package:
  name: fp_compare_unit

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/fp_cmp_pkg.sv
      - rtl/fp_pair_classifier.sv
      - rtl/fp_order_compare.sv
      - rtl/fp_compare_select.sv
      - rtl/fp_compare_unit.sv

  - target: test
    include_dirs:
      - rtl
    files:
      - verification/fp_compare_checker.sv
      - verification/fp_compare_tb.sv
